//--- verilog.f
+incdir+sim
rtl/coms_pkg.sv
rtl/crc16_accum.sv
rtl/frame_receiver.sv
rtl/reply_sender.sv
rtl/motor_coms.sv
sim/tb_motor_coms.sv

//--- sim/tb_frames.svh
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

typedef struct packed {
	coms_pkg::frame_kind_t   kind;
	logic [7:0]              id;
	logic [31:0]             payload;
	logic                    corrupt;
	logic [2:0]              noise_cnt;
	logic [4:0]              exp_len;
	coms_pkg::motor_status_t status;
} stim_row_t;

localparam int NUM_ROWS  = 10;
localparam int MAX_NOISE = 7;

// x^16 + x^15 + x^2 + 1
localparam logic [15:0] POLY_TAPS = 16'h8005;

stim_row_t  rows [NUM_ROWS];
logic [7:0] req_bytes [$];
logic [7:0] exp_reply [$];

function automatic stim_row_t make_row(coms_pkg::frame_kind_t kind, logic [7:0] id,
		logic [31:0] payload, logic corrupt, logic [2:0] noise_cnt, logic [4:0] exp_len);
	stim_row_t row;
	row           = '0;
	row.kind      = kind;
	row.id        = id;
	row.payload   = payload;
	row.corrupt   = corrupt;
	row.noise_cnt = noise_cnt;
	row.exp_len   = exp_len;
	return row;
endfunction

// kind, id, payload, crc corrupt, noise bytes, reply length
task automatic load_table();
	rows[0] = make_row(coms_pkg::KIND_STATUS_REQ,   8'h11, 32'h0000_0000, 1'b0, 3'd0, 5'd21);
	rows[1] = make_row(coms_pkg::KIND_SETPOINT,     8'h11, 32'h1234_5678, 1'b0, 3'd3, 5'd1);
	rows[2] = make_row(coms_pkg::KIND_CONTROL_MODE, 8'h22, 32'h0000_0005, 1'b0, 3'd0, 5'd1);
	rows[3] = make_row(coms_pkg::KIND_SETPOINT,     8'h22, 32'hFFFF_8000, 1'b1, 3'd2, 5'd1);
	rows[4] = make_row(coms_pkg::KIND_CONTROL_MODE, 8'h22, 32'h0000_0009, 1'b1, 3'd1, 5'd1);
	rows[5] = make_row(coms_pkg::KIND_STATUS_REQ,   8'h33, 32'h0000_0000, 1'b1, 3'd0, 5'd1);
	rows[6] = make_row(coms_pkg::KIND_STATUS_REQ,   8'h7F, 32'h0000_0000, 1'b0, 3'd5, 5'd21);
	rows[7] = make_row(coms_pkg::KIND_SETPOINT,     8'h7F, 32'h8000_0001, 1'b0, 3'd1, 5'd1);
	rows[8] = make_row(coms_pkg::KIND_CONTROL_MODE, 8'hC4, 32'h0000_00A3, 1'b0, 3'd4, 5'd1);
	rows[9] = make_row(coms_pkg::KIND_STATUS_REQ,   8'hC4, 32'h0000_0000, 1'b0, 3'd2, 5'd21);
endtask

// reference crc with each byte xored into the top and shifted out msb first
function automatic logic [15:0] crc_range(input logic [7:0] q [$], input int first,
		input int last);
	logic [15:0] r;
	int          k;
	int          b;
	r = coms_pkg::CRC_INIT;
	for (k = first; k <= last; k++) begin
		r = r ^ {q[k], 8'h00};
		for (b = 0; b < 8; b++)
			r = r[15] ? ({r[14:0], 1'b0} ^ POLY_TAPS) : {r[14:0], 1'b0};
	end
	return r;
endfunction

task automatic build_request(input stim_row_t row);
	logic [31:0] magic;
	logic [15:0] crc;
	int          i;
	req_bytes.delete();
	case (row.kind)
		coms_pkg::KIND_SETPOINT:     magic = coms_pkg::SETPOINT_MAGIC;
		coms_pkg::KIND_CONTROL_MODE: magic = coms_pkg::CONTROL_MODE_MAGIC;
		default:                     magic = coms_pkg::STATUS_REQ_MAGIC;
	endcase
	for (i = 3; i >= 0; i--)
		req_bytes.push_back(magic[8*i +: 8]);
	req_bytes.push_back(row.id);
	if (row.kind == coms_pkg::KIND_SETPOINT) begin
		for (i = 3; i >= 0; i--)
			req_bytes.push_back(row.payload[8*i +: 8]);
	end else if (row.kind == coms_pkg::KIND_CONTROL_MODE) begin
		req_bytes.push_back(row.payload[7:0]);
	end
	crc = crc_range(req_bytes, coms_pkg::MAGIC_LEN, req_bytes.size() - 1);
	// odd ids get the high crc byte flipped and even ids the low one
	if (row.corrupt) begin
		if (row.id[0])
			crc[15:8] = ~crc[15:8];
		else
			crc[7:0] = ~crc[7:0];
	end
	req_bytes.push_back(crc[15:8]);
	req_bytes.push_back(crc[7:0]);
endtask

task automatic build_reply(input stim_row_t row);
	logic [31:0]  magic;
	logic [111:0] fields;
	logic [15:0]  crc;
	int           i;
	exp_reply.delete();
	if (row.kind == coms_pkg::KIND_STATUS_REQ && !row.corrupt) begin
		magic  = coms_pkg::STATUS_MAGIC;
		fields = row.status;
		for (i = 3; i >= 0; i--)
			exp_reply.push_back(magic[8*i +: 8]);
		exp_reply.push_back(row.id);
		for (i = 13; i >= 0; i--)
			exp_reply.push_back(fields[8*i +: 8]);
		crc = crc_range(exp_reply, coms_pkg::MAGIC_LEN,
			coms_pkg::STATUS_LEN - coms_pkg::CRC_LEN - 1);
		exp_reply.push_back(crc[15:8]);
		exp_reply.push_back(crc[7:0]);
	end else begin
		exp_reply.push_back(row.corrupt ? coms_pkg::NACK_BYTE : coms_pkg::ACK_BYTE);
	end
endtask

`endif

//--- sim/tb_motor_coms.sv
`timescale 1ns/1ps

module tb_motor_coms;

	`include "tb_frames.svh"

	localparam int CLK_PERIOD  = 20;
	// row count x 40 bytes x 8 cycles
	localparam int WATCHDOG_NS = NUM_ROWS * 40 * 8 * CLK_PERIOD;

	logic                    CLK;
	logic                    reset;
	logic                    rx_valid;
	logic [7:0]              rx_data;
	logic [7:0]              motor_id;
	coms_pkg::motor_status_t status;
	logic                    tx_ready;
	logic                    tx_valid;
	logic [7:0]              tx_data;
	logic signed [31:0]      setpoint;
	logic [7:0]              control_mode;

	integer             seed = 56;
	logic [7:0]         noise [NUM_ROWS][MAX_NOISE];
	logic signed [31:0] exp_setpoint;
	logic [7:0]         exp_mode;

	motor_coms i_motor_coms (
		.CLK          (CLK),
		.reset        (reset),
		.rx_valid     (rx_valid),
		.rx_data      (rx_data),
		.motor_id     (motor_id),
		.status       (status),
		.tx_ready     (tx_ready),
		.tx_valid     (tx_valid),
		.tx_data      (tx_data),
		.setpoint     (setpoint),
		.control_mode (control_mode)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// tx_ready high in about three cycles of four
	always @(negedge CLK) begin
		tx_ready = ($random(seed) & 3) != 0;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// one byte, then one idle cycle
	task automatic send_byte(input logic [7:0] b);
		@(negedge CLK);
		rx_valid = 1'b1;
		rx_data  = b;
		@(negedge CLK);
		rx_valid = 1'b0;
	endtask

	task automatic collect_reply(input int row_idx, input int count);
		int got;
		got = 0;
		while (got < count) begin
			@(posedge CLK);
			if (tx_valid && tx_ready) begin
				check_value(tx_data, exp_reply[got],
					$sformatf("row %0d reply byte %0d", row_idx, got));
				got++;
			end
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int r;
		int k;
		CLK          = 1'b0;
		reset        = 1'b1;
		rx_valid     = 1'b0;
		rx_data      = '0;
		motor_id     = '0;
		status       = '0;
		tx_ready     = 1'b0;
		exp_setpoint = '0;
		exp_mode     = '0;
		load_table();
		for (r = 0; r < NUM_ROWS; r++) begin
			rows[r].status.position     = $random(seed);
			rows[r].status.velocity     = $random(seed);
			rows[r].status.displacement = $random(seed);
			rows[r].status.current      = 16'($random(seed));
			for (k = 0; k < MAX_NOISE; k++)
				noise[r][k] = 8'($random(seed));
		end

		repeat (3) @(negedge CLK);
		reset = 1'b0;
		@(posedge CLK);
		check_value(tx_valid, 1'b0, "tx_valid after reset");
		check_value(setpoint, 32'd0, "setpoint after reset");
		check_value(control_mode, 8'd0, "control_mode after reset");

		for (r = 0; r < NUM_ROWS; r++) begin
			@(negedge CLK);
			motor_id = rows[r].id;
			status   = rows[r].status;
			build_request(rows[r]);
			build_reply(rows[r]);
			for (k = 0; k < rows[r].noise_cnt; k++)
				send_byte(noise[r][k]);
			for (k = 0; k < req_bytes.size(); k++)
				send_byte(req_bytes[k]);
			collect_reply(r, rows[r].exp_len);

			if (!rows[r].corrupt && rows[r].kind == coms_pkg::KIND_SETPOINT)
				exp_setpoint = rows[r].payload;
			if (!rows[r].corrupt && rows[r].kind == coms_pkg::KIND_CONTROL_MODE)
				exp_mode = rows[r].payload[7:0];
			check_value(setpoint, exp_setpoint, $sformatf("row %0d setpoint", r));
			check_value(control_mode, exp_mode, $sformatf("row %0d control_mode", r));

			// no extra reply byte may follow
			repeat (4) begin
				@(posedge CLK);
				check_value(tx_valid, 1'b0, $sformatf("row %0d tx_valid after reply", r));
			end
		end

		$display("All tests passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: a reply did not arrive in time");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- rtl/motor_coms.sv
`timescale 1ns/1ps

module motor_coms (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    rx_valid,
	input  logic [7:0]              rx_data,
	input  logic [7:0]              motor_id,
	input  coms_pkg::motor_status_t status,
	input  logic                    tx_ready,
	output logic                    tx_valid,
	output logic [7:0]              tx_data,
	output logic signed [31:0]      setpoint,
	output logic [7:0]              control_mode
);

	// verdict channel between receive and reply sides
	logic                  verdict_valid;
	logic                  verdict_ready;
	coms_pkg::rx_verdict_t verdict;

	frame_receiver i_frame_receiver (
		.CLK           (CLK),
		.reset         (reset),
		.rx_valid      (rx_valid),
		.rx_data       (rx_data),
		.verdict_ready (verdict_ready),
		.verdict_valid (verdict_valid),
		.verdict       (verdict)
	);

	reply_sender i_reply_sender (
		.CLK           (CLK),
		.reset         (reset),
		.verdict_valid (verdict_valid),
		.verdict       (verdict),
		.motor_id      (motor_id),
		.status        (status),
		.tx_ready      (tx_ready),
		.verdict_ready (verdict_ready),
		.tx_valid      (tx_valid),
		.tx_data       (tx_data),
		.setpoint      (setpoint),
		.control_mode  (control_mode)
	);

endmodule

//--- rtl/reply_sender.sv
`timescale 1ns/1ps

module reply_sender (
	input  logic                    CLK,
	input  logic                    reset,
	input  logic                    verdict_valid,
	input  coms_pkg::rx_verdict_t   verdict,
	input  logic [7:0]              motor_id,
	input  coms_pkg::motor_status_t status,
	input  logic                    tx_ready,
	output logic                    verdict_ready,
	output logic                    tx_valid,
	output logic [7:0]              tx_data,
	output logic signed [31:0]      setpoint,
	output logic [7:0]              control_mode
);

	// status frame bytes ahead of the crc
	localparam int BODY_END = coms_pkg::STATUS_LEN - coms_pkg::CRC_LEN;

	typedef enum logic [1:0] {
		ST_START,
		ST_IDLE,
		ST_SEND
	} state_t;

	state_t                  state;
	logic [4:0]              byte_idx;
	logic                    status_reply;
	logic [7:0]              single_byte;
	logic [8*BODY_END-1:0]   status_frame;
	logic [15:0]             crc;
	logic                    take_verdict;
	logic                    tx_done;
	logic                    crc_update;
	logic                    good;

	assign verdict_ready = (state == ST_IDLE);
	assign tx_valid      = (state == ST_SEND);
	assign take_verdict  = verdict_valid && verdict_ready;
	assign tx_done       = tx_valid && tx_ready;
	assign good          = verdict.crc_good;

	//////////////////////////////
	// reply byte select
	//////////////////////////////

	assign status_frame = {coms_pkg::STATUS_MAGIC, motor_id, status};

	always_comb begin
		if (!status_reply)
			tx_data = single_byte;
		else if (byte_idx < 5'(BODY_END))
			tx_data = status_frame[8 * (BODY_END - 1 - byte_idx) +: 8];
		else if (byte_idx == 5'(BODY_END))
			tx_data = crc[15:8];
		else
			tx_data = crc[7:0];
	end

	// crc covers id and status fields only
	assign crc_update = tx_done && status_reply &&
		(byte_idx >= 5'(coms_pkg::MAGIC_LEN)) && (byte_idx < 5'(BODY_END));

	//////////////////////////////
	// sequencing
	//////////////////////////////

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state        <= ST_START;
			byte_idx     <= '0;
			status_reply <= 1'b0;
			setpoint     <= '0;
			control_mode <= '0;
		end else begin
			case (state)
				ST_START: begin
					state <= ST_IDLE;
				end
				ST_IDLE: begin
					if (verdict_valid) begin
						state        <= ST_SEND;
						byte_idx     <= '0;
						status_reply <= good &&
							(verdict.kind == coms_pkg::KIND_STATUS_REQ);
						// commands take effect on the handshake edge
						if (good && verdict.kind == coms_pkg::KIND_SETPOINT)
							setpoint <= verdict.payload.setpoint;
						if (good && verdict.kind == coms_pkg::KIND_CONTROL_MODE)
							control_mode <= verdict.payload.ctrl.mode;
					end
				end
				ST_SEND: begin
					if (tx_ready) begin
						if (status_reply && byte_idx != 5'(coms_pkg::STATUS_LEN - 1))
							byte_idx <= byte_idx + 5'd1;
						else
							state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (take_verdict)
			single_byte <= good ? coms_pkg::ACK_BYTE : coms_pkg::NACK_BYTE;
	end

	crc16_accum i_crc (
		.CLK    (CLK),
		.reset  (reset),
		.clear  (take_verdict),
		.update (crc_update),
		.data   (tx_data),
		.crc    (crc)
	);

	// also relies on motor_id and status being held by the outside
	a_tx_hold: assert property (@(posedge CLK) disable iff (reset)
		(tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

//--- rtl/frame_receiver.sv
`timescale 1ns/1ps

module frame_receiver (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  rx_valid,
	input  logic [7:0]            rx_data,
	input  logic                  verdict_ready,
	output logic                  verdict_valid,
	output coms_pkg::rx_verdict_t verdict
);

	logic [31:0]           hunt;
	coms_pkg::frame_kind_t match_kind;
	coms_pkg::frame_kind_t kind_q;
	coms_pkg::frame_kind_t cur_kind;
	logic [2:0]            cur_len;
	logic [2:0]            body_cnt;
	logic [1:0]            pay_idx;
	logic [31:0]           payload_word;
	logic                  crc_hi_ok;
	logic [15:0]           crc;
	logic                  rx_accept;
	logic                  body_byte;
	logic                  crc_update;
	logic                  crc_hi_byte;
	logic                  last_byte;

	// bytes after the magic number, crc included
	function automatic logic [2:0] body_len(coms_pkg::frame_kind_t kind);
		case (kind)
			coms_pkg::KIND_STATUS_REQ:
				body_len = 3'(coms_pkg::STATUS_REQ_LEN - coms_pkg::MAGIC_LEN);
			coms_pkg::KIND_SETPOINT:
				body_len = 3'(coms_pkg::SETPOINT_LEN - coms_pkg::MAGIC_LEN);
			coms_pkg::KIND_CONTROL_MODE:
				body_len = 3'(coms_pkg::CONTROL_MODE_LEN - coms_pkg::MAGIC_LEN);
			default:
				body_len = 3'd0;
		endcase
	endfunction

	//////////////////////////////
	// magic number hunt
	//////////////////////////////

	always_comb begin
		case (hunt)
			coms_pkg::STATUS_REQ_MAGIC:   match_kind = coms_pkg::KIND_STATUS_REQ;
			coms_pkg::SETPOINT_MAGIC:     match_kind = coms_pkg::KIND_SETPOINT;
			coms_pkg::CONTROL_MODE_MAGIC: match_kind = coms_pkg::KIND_CONTROL_MODE;
			default:                      match_kind = coms_pkg::KIND_NONE;
		endcase
	end

	// a match counts at once, so a byte right behind the magic is body
	assign cur_kind  = (kind_q != coms_pkg::KIND_NONE) ? kind_q : match_kind;
	assign cur_len   = body_len(cur_kind);

	// bytes are dropped while a verdict waits
	assign rx_accept   = rx_valid && !verdict_valid;
	assign body_byte   = rx_accept && (cur_kind != coms_pkg::KIND_NONE);
	assign crc_update  = body_byte && (body_cnt < cur_len - 3'd2);
	assign crc_hi_byte = body_byte && (body_cnt == cur_len - 3'd2);
	assign last_byte   = body_byte && (body_cnt == cur_len - 3'd1);

	// payload byte k lands at bits 31-8k, so a mode byte ends up on top
	assign pay_idx = body_cnt[1:0] - 2'd1;

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			hunt          <= '0;
			kind_q        <= coms_pkg::KIND_NONE;
			body_cnt      <= '0;
			verdict_valid <= 1'b0;
		end else begin
			if (last_byte) begin
				hunt     <= '0;
				kind_q   <= coms_pkg::KIND_NONE;
				body_cnt <= '0;
			end else begin
				kind_q <= cur_kind;
				if (body_byte)
					body_cnt <= body_cnt + 3'd1;
				else if (rx_accept)
					hunt <= {hunt[23:0], rx_data};
			end

			if (verdict_valid && verdict_ready)
				verdict_valid <= 1'b0;
			else if (last_byte)
				verdict_valid <= 1'b1;
		end
	end

	//////////////////////////////
	// payload and crc compare
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (crc_update && body_cnt != 3'd0)
			payload_word[{~pay_idx, 3'b000} +: 8] <= rx_data;
		if (crc_hi_byte)
			crc_hi_ok <= (rx_data == crc[15:8]);
		if (last_byte) begin
			verdict.kind     <= cur_kind;
			verdict.crc_good <= crc_hi_ok && (rx_data == crc[7:0]);
			verdict.payload  <= payload_word;
		end
	end

	// register restarts when the frame closes, ready for the next one
	crc16_accum i_crc (
		.CLK    (CLK),
		.reset  (reset),
		.clear  (last_byte),
		.update (crc_update),
		.data   (rx_data),
		.crc    (crc)
	);

	a_body_cnt_bound: assert property (@(posedge CLK) disable iff (reset)
		(kind_q != coms_pkg::KIND_NONE) |-> (body_cnt < body_len(kind_q)));

endmodule

//--- rtl/crc16_accum.sv
`timescale 1ns/1ps

module crc16_accum (
	input  logic        CLK,
	input  logic        reset,
	input  logic        clear,
	input  logic        update,
	input  logic [7:0]  data,
	output logic [15:0] crc
);

	localparam logic [15:0] POLY = 16'h8005;

	logic [15:0] crc_next;

	// eight serial steps, data msb shifted in first
	always_comb begin
		crc_next = crc;
		for (int i = 7; i >= 0; i--) begin
			if (crc_next[15] ^ data[i])
				crc_next = {crc_next[14:0], 1'b0} ^ POLY;
			else
				crc_next = {crc_next[14:0], 1'b0};
		end
	end

	always_ff @(posedge CLK or posedge reset) begin
		if (reset)
			crc <= coms_pkg::CRC_INIT;
		else if (clear)
			crc <= coms_pkg::CRC_INIT;
		else if (update)
			crc <= crc_next;
	end

	// the owning FSM never restarts and advances in the same cycle
	a_clear_update_excl: assert property (@(posedge CLK) disable iff (reset)
		!(clear && update));

endmodule

//--- rtl/coms_pkg.sv
package coms_pkg;

	//////////////////////////////
	// protocol constants
	//////////////////////////////

	// request frames seen by the motor board
	localparam logic [31:0] STATUS_REQ_MAGIC   = 32'hDABBAD00;
	localparam logic [31:0] SETPOINT_MAGIC     = 32'hB16B00B5;
	localparam logic [31:0] CONTROL_MODE_MAGIC = 32'hBAADA555;

	// reply frame sent back for a status request
	localparam logic [31:0] STATUS_MAGIC       = 32'h1CEB00DA;

	localparam int MAGIC_LEN        = 4;
	localparam int CRC_LEN          = 2;

	// magic, id, crc
	localparam int STATUS_REQ_LEN   = 7;
	// magic, id, setpoint msb first, crc
	localparam int SETPOINT_LEN     = 11;
	// magic, id, mode, crc
	localparam int CONTROL_MODE_LEN = 8;
	// magic, id, position, velocity, displacement, current, crc
	localparam int STATUS_LEN       = 21;

	// crc-16 x^16+x^15+x^2+1, register preset, no final xor
	localparam logic [15:0] CRC_INIT = 16'hFFFF;

	localparam logic [7:0] ACK_BYTE  = 8'hFF;
	localparam logic [7:0] NACK_BYTE = 8'h00;

	//////////////////////////////
	// shared types
	//////////////////////////////

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_STATUS_REQ,
		KIND_SETPOINT,
		KIND_CONTROL_MODE
	} frame_kind_t;

	// one collected payload word, read according to the frame kind
	typedef union packed {
		logic signed [31:0] setpoint;
		struct packed {
			logic [7:0]  mode;
			logic [23:0] unused;
		} ctrl;
	} cmd_payload_u;

	typedef struct packed {
		frame_kind_t  kind;
		logic         crc_good;
		cmd_payload_u payload;
	} rx_verdict_t;

	// field order matches the byte order of the status frame
	typedef struct packed {
		logic signed [31:0] position;
		logic signed [31:0] velocity;
		logic signed [31:0] displacement;
		logic [15:0]        current;
	} motor_status_t;

endpackage
